// File: Bender.yml
package:
  name: mlp_controller

sources:
  - verilog/mlp_pkg.sv
  - verilog/layer_sequencer.sv
  - verilog/slice_streamer.sv
  - verilog/psum_fetch.sv
  - verilog/psum_add_tree.sv
  - verilog/if_neuron.sv
  - verilog/mlp_controller.sv
  - target: test
    files:
      - tb/tb_mlp_controller.sv

// File: flist.f
verilog/mlp_pkg.sv
verilog/layer_sequencer.sv
verilog/slice_streamer.sv
verilog/psum_fetch.sv
verilog/psum_add_tree.sv
verilog/if_neuron.sv
verilog/mlp_controller.sv
tb/tb_mlp_controller.sv

// File: tb/tb_mlp_controller.sv
`timescale 1ns/1ps

module tb_mlp_controller;
    import mlp_pkg::*;

    localparam int N_UNIT       = 4;
    localparam int SLICE_BEATS  = 8;
    localparam int FETCH_BEATS  = N_UNIT * N_UNIT;
    localparam int TOTAL_BLOCKS = 8;
    localparam int RUN_TIMEOUT  = 20000;
    localparam int DRAIN_LIMIT  = 50;

    // layer shapes, thresholds and bias bases
    localparam int ROWS [3]      = '{3, 3, 6};
    localparam int COLS [3]      = '{2, 4, 2};
    localparam int THRD [3]      = '{128, 256, 128};
    localparam int BIAS_BASE [3] = '{0, 8, 24};

    logic                             s_clk;
    logic                             s_rst;
    logic                             i_start;
    logic [ACT_W-1:0]                 i_act_data;
    logic [N_ARRAYS-1:0]              i_slice_ready;
    logic [N_ARRAYS-1:0][PSUM_W-1:0]  i_psum_data;
    logic [N_ARRAYS-1:0]              i_finish;
    logic signed [BIAS_W-1:0]         i_bias_data;
    layer_idx_t                       o_act_bank;
    logic [7:0]                       o_act_addr;
    logic [N_ARRAYS-1:0]              o_slice_valid;
    logic [N_ARRAYS-1:0]              o_slice_done;
    logic [ACT_W-1:0]                 o_slice_data;
    logic [N_UNIT-1:0]                o_psum_grant;
    logic                             o_psum_valid;
    logic [7:0]                       o_bias_addr;
    logic                             o_spike_valid;
    logic [TIME_STEPS-1:0]            o_spikes;
    logic                             o_calc_done;

    logic [15:0]           lfsr_state = 16'd25197;
    int                    bias_mem [256];
    logic [1:0]            act_bank_q = '0;
    logic [7:0]            act_addr_q = '0;
    logic [7:0]            bias_addr_q = '0;
    int                    fin_delay [N_ARRAYS];
    logic [N_ARRAYS-1:0]   ready_hist [3];
    logic [N_ARRAYS-1:0]   fin_got;
    logic [TIME_STEPS-1:0] spike_q [$];
    int                    beat_cyc_q [$];
    int                    cycle;
    int                    exp_layer;
    int                    exp_col;
    int                    exp_row;
    int                    exp_chan;
    int                    slice_beat;
    int                    fetch_beat;
    logic                  slice_active;
    logic                  fetch_active;
    logic                  done_prev;
    int                    blocks_done;
    int                    slices_total;
    int                    spikes_seen;

    mlp_controller #(
        .N_UNIT         (N_UNIT),
        .SLICE_BEATS    (SLICE_BEATS)
    ) i_mlp_controller (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_start        (i_start),
        .i_act_data     (i_act_data),
        .i_slice_ready  (i_slice_ready),
        .i_psum_data    (i_psum_data),
        .i_finish       (i_finish),
        .i_bias_data    (i_bias_data),
        .o_act_bank     (o_act_bank),
        .o_act_addr     (o_act_addr),
        .o_slice_valid  (o_slice_valid),
        .o_slice_done   (o_slice_done),
        .o_slice_data   (o_slice_data),
        .o_psum_grant   (o_psum_grant),
        .o_psum_valid   (o_psum_valid),
        .o_bias_addr    (o_bias_addr),
        .o_spike_valid  (o_spike_valid),
        .o_spikes       (o_spikes),
        .o_calc_done    (o_calc_done)
    );

    always #4 s_clk = ~s_clk;

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic rand_bit();
        logic fb;
        fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
        lfsr_state = {lfsr_state[14:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], rand_bit()};
        end
        return v;
    endfunction

    function automatic int rand_signed(input int n);
        logic [31:0] v;
        v = rand_bits(n);
        if (v[n-1]) begin
            return int'(v) - (1 << n);
        end
        return int'(v);
    endfunction

    // activation memory content, mixes bank and address
    function automatic logic [ACT_W-1:0] act_word(input logic [1:0] bank, input logic [7:0] addr);
        logic [9:0] key;
        key = {bank, addr};
        return {22'h0, key, 16'(key * 16'd40503), 16'hC0DE ^ {6'h0, key}};
    endfunction

    function automatic logic [TIME_STEPS-1:0] expected_spikes(
        input logic [N_ARRAYS-1:0][PSUM_W-1:0] psum,
        input int                              bias,
        input int                              thrd
    );
        int                       pot;
        int                       step;
        logic signed [LANE_W-1:0] lane;
        logic [TIME_STEPS-1:0]    spk;
        pot = 0;
        spk = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            step = bias;
            for (int a = 0; a < N_ARRAYS; a++) begin
                lane = psum[a][t*LANE_W +: LANE_W];
                step = step + lane;
            end
            pot = pot + step;
            if (pot >= thrd) begin
                spk[t] = 1'b1;
                pot    = 0;
            end
        end
        return spk;
    endfunction

    task automatic check_value(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            $display("error at %0t: %s, got 0x%0h, expected 0x%0h", $time, what, got, exp);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout at %0t: %s", $time, what);
        $display("Test failed");
        $fatal(1);
    endtask

    // arrays report finish some cycles after their last slice
    task automatic arm_finish();
        for (int a = 0; a < N_ARRAYS; a++) begin
            fin_delay[a] = 1 + int'(rand_bits(3));
        end
    endtask

    task automatic monitor_slices();
        int ch;
        ch = 0;
        if (|o_slice_valid) begin
            check_value($countones(o_slice_valid), 1, "slice valid channels");
            for (int c = 0; c < N_ARRAYS; c++) begin
                if (o_slice_valid[c]) begin
                    ch = c;
                end
            end
            if (!slice_active) begin
                check_value(exp_row < ROWS[exp_layer], 1, "slice within row count");
                // launch decision was three cycles before the first beat
                check_value(ready_hist[2][exp_chan], 1, "slice launched with ready high");
                slice_active = 1'b1;
                slice_beat   = 0;
            end
            check_value(ch, exp_chan, "slice channel");
            check_value(o_slice_data,
                        act_word(2'(exp_layer), 8'(exp_row * SLICE_BEATS + slice_beat)),
                        "slice data");
            check_value(o_slice_done, (slice_beat == SLICE_BEATS - 1) ? (1 << exp_chan) : 0,
                        "slice done");
            slice_beat++;
            if (slice_beat == SLICE_BEATS) begin
                slice_active = 1'b0;
                exp_chan     = (exp_chan + 1) % N_ARRAYS;
                exp_row++;
                slices_total++;
                if (exp_row == ROWS[exp_layer]) begin
                    arm_finish();
                end
            end
        end else begin
            check_value(slice_active, 0, "slice valid held until done");
            check_value(o_slice_done, 0, "slice done without valid");
        end
    endtask

    task automatic monitor_fetch();
        int bidx;
        if (o_psum_valid) begin
            if (!fetch_active) begin
                check_value(exp_row, ROWS[exp_layer], "slices before fetch");
                check_value(fin_got, {N_ARRAYS{1'b1}}, "finish from all arrays before fetch");
                fin_got      = '0;
                fetch_active = 1'b1;
                fetch_beat   = 0;
            end
            bidx = BIAS_BASE[exp_layer] + exp_col * N_UNIT + fetch_beat / N_UNIT;
            check_value(o_psum_grant, 1 << (fetch_beat / N_UNIT), "psum grant");
            check_value(o_bias_addr, bidx, "bias address");
            spike_q.push_back(expected_spikes(i_psum_data, bias_mem[bidx], THRD[exp_layer]));
            beat_cyc_q.push_back(cycle);
            fetch_beat++;
            if (fetch_beat == FETCH_BEATS) begin
                fetch_active = 1'b0;
                blocks_done++;
                exp_row = 0;
                exp_col++;
                if (exp_col == COLS[exp_layer]) begin
                    exp_col = 0;
                    exp_layer++;
                end
            end
        end else begin
            check_value(fetch_active, 0, "psum valid held for the whole fetch");
            check_value(o_psum_grant, 0, "psum grant outside a fetch");
        end
    endtask

    task automatic monitor_spikes();
        if (o_spike_valid) begin
            check_value(spike_q.size() != 0, 1, "psum beat in flight for spike");
            check_value(cycle - beat_cyc_q.pop_front(), 3, "spike latency");
            check_value(o_spikes, spike_q.pop_front(), "spikes");
            spikes_seen++;
        end
    endtask

    // outputs are sampled on the falling edge
    always @(negedge s_clk) begin
        cycle++;
        act_bank_q  = o_act_bank;
        act_addr_q  = o_act_addr;
        bias_addr_q = o_bias_addr;
        monitor_spikes();
        monitor_slices();
        monitor_fetch();
        if (o_calc_done && !done_prev) begin
            check_value(blocks_done, TOTAL_BLOCKS, "blocks fetched when calc done rose");
        end
        done_prev     = o_calc_done;
        ready_hist[2] = ready_hist[1];
        ready_hist[1] = ready_hist[0];
        ready_hist[0] = i_slice_ready;
        fin_got       = fin_got | i_finish;
    end

    // memories answer the address seen in the previous cycle
    always @(posedge s_clk) begin
        #1;
        i_act_data  = act_word(act_bank_q, act_addr_q);
        i_bias_data = BIAS_W'(bias_mem[bias_addr_q]);
        for (int a = 0; a < N_ARRAYS; a++) begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                i_psum_data[a][t*LANE_W +: LANE_W] = LANE_W'(rand_signed(9));
            end
            i_slice_ready[a] = rand_bit() | rand_bit();
            i_finish[a]      = (fin_delay[a] == 1);
            if (fin_delay[a] > 0) begin
                fin_delay[a]--;
            end
        end
    end

    task automatic start_run();
        @(posedge s_clk);
        #1;
        exp_layer    = 0;
        exp_col      = 0;
        exp_row      = 0;
        exp_chan     = 0;
        blocks_done  = 0;
        slices_total = 0;
        spikes_seen  = 0;
        slice_active = 1'b0;
        fetch_active = 1'b0;
        i_start      = 1'b1;
        @(posedge s_clk);
        #1;
        i_start = 1'b0;
        @(negedge s_clk);
        check_value(o_calc_done, 0, "calc done after start");
    endtask

    task automatic wait_calc_done();
        int n;
        n = 0;
        while (o_calc_done !== 1'b1 && n < RUN_TIMEOUT) begin
            @(negedge s_clk);
            n++;
        end
        if (o_calc_done !== 1'b1) begin
            report_timeout("calc done did not rise within the cycle limit");
        end
    endtask

    task automatic wait_spike_drain();
        int n;
        n = 0;
        while (spike_q.size() != 0 && n < DRAIN_LIMIT) begin
            @(posedge s_clk);
            n++;
        end
        if (spike_q.size() != 0) begin
            report_timeout("spikes missing for fetched psum beats");
        end
    endtask

    task automatic check_run_totals();
        int slc;
        slc = 0;
        for (int l = 0; l < 3; l++) begin
            slc = slc + COLS[l] * ROWS[l];
        end
        check_value(blocks_done, TOTAL_BLOCKS, "column blocks fetched");
        check_value(slices_total, slc, "slices streamed");
        check_value(spikes_seen, TOTAL_BLOCKS * FETCH_BEATS, "spike beats");
        check_value(o_calc_done, 1, "calc done held");
    endtask

    initial begin
        s_clk         = 1'b0;
        s_rst         = 1'b1;
        i_start       = 1'b0;
        i_act_data    = '0;
        i_slice_ready = '0;
        i_psum_data   = '0;
        i_finish      = '0;
        i_bias_data   = '0;
        cycle         = 0;
        done_prev     = 1'b0;
        slice_active  = 1'b0;
        fetch_active  = 1'b0;
        fin_got       = '0;
        for (int i = 0; i < 3; i++) begin
            ready_hist[i] = '0;
        end
        for (int a = 0; a < N_ARRAYS; a++) begin
            fin_delay[a] = 0;
        end
        for (int i = 0; i < 256; i++) begin
            bias_mem[i] = rand_signed(8);
        end
        repeat (16) @(posedge s_clk);
        #1;
        s_rst = 1'b0;
        @(negedge s_clk);
        check_value(o_slice_valid, 0, "slice valid after reset");
        check_value(o_psum_valid, 0, "psum valid after reset");
        check_value(o_psum_grant, 0, "psum grant after reset");
        check_value(o_spike_valid, 0, "spike valid after reset");
        check_value(o_calc_done, 0, "calc done after reset");
        // second run must repeat the same counts
        for (int run = 0; run < 2; run++) begin
            start_run();
            wait_calc_done();
            wait_spike_drain();
            check_run_totals();
        end
        $display("Test completed successfully");
        $finish;
    end

endmodule

// File: verilog/if_neuron.sv
`timescale 1ns/1ps

module if_neuron (
    input  logic                                                s_clk,
    input  logic                                                s_rst,
    input  logic                                                i_valid,
    input  mlp_pkg::layer_idx_t                                 i_layer,
    input  logic [mlp_pkg::TIME_STEPS-1:0][mlp_pkg::SUM_W-1:0]  i_sum,
    output logic                                                o_spike_valid,
    output logic [mlp_pkg::TIME_STEPS-1:0]                      o_spikes
);
    import mlp_pkg::*;

    // headroom for four steps without a spike
    localparam int POT_W = SUM_W + 2;

    logic signed [POT_W-1:0] pot;
    logic signed [POT_W-1:0] thrd;
    logic [TIME_STEPS-1:0]   spikes_c;

    assign thrd = POT_W'(LAYER_THRD[i_layer]);

    // step 0 first, potential cleared on each spike
    always_comb begin
        pot      = '0;
        spikes_c = '0;
        for (int t = 0; t < TIME_STEPS; t++) begin
            pot = pot + POT_W'($signed(i_sum[t]));
            if (pot >= thrd) begin
                spikes_c[t] = 1'b1;
                pot         = '0;
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_spike_valid <= 1'b0;
            o_spikes      <= '0;
        end else begin
            o_spike_valid <= i_valid;
            if (i_valid) begin
                o_spikes <= spikes_c;
            end
        end
    end

endmodule

// File: verilog/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer #(
    parameter int N_UNIT = 4
) (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         i_start,
    input  logic                         i_slice_end,
    input  logic [mlp_pkg::N_ARRAYS-1:0] i_finish,
    input  logic                         i_fetch_end,
    output mlp_pkg::layer_idx_t          o_layer,
    output logic [7:0]                   o_col_blk,
    output logic [7:0]                   o_row_cnt,
    output logic                         o_stream_en,
    output logic                         o_fetch_start,
    output logic                         o_calc_done
);
    import mlp_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_STREAM,
        S_WAIT_FIN,
        S_FETCH
    } state_t;

    state_t              state;
    logic [N_ARRAYS-1:0] fin_seen;
    logic                last_row;
    logic                last_col;
    logic                last_layer;
    logic                fetch_go;

    assign last_row    = (o_row_cnt == 8'(LAYER_ROWS[o_layer] - 1));
    assign last_col    = (o_col_blk == 8'(LAYER_COLS[o_layer] - 1));
    assign last_layer  = (o_layer == layer_idx_t'(NUM_LAYERS - 1));
    assign fetch_go    = (state == S_WAIT_FIN) && (&fin_seen);
    assign o_stream_en = (state == S_STREAM);

    // finish pulses may arrive before the wait state is reached
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            fin_seen <= '0;
        end else if (fetch_go || (state == S_IDLE && i_start)) begin
            fin_seen <= '0;
        end else begin
            fin_seen <= fin_seen | i_finish;
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            state         <= S_IDLE;
            o_layer       <= '0;
            o_col_blk     <= '0;
            o_row_cnt     <= '0;
            o_fetch_start <= 1'b0;
            o_calc_done   <= 1'b0;
        end else begin
            o_fetch_start <= 1'b0;
            case (state)
                S_IDLE: begin
                    if (i_start) begin
                        o_layer     <= '0;
                        o_col_blk   <= '0;
                        o_row_cnt   <= '0;
                        o_calc_done <= 1'b0;
                        state       <= S_STREAM;
                    end
                end
                S_STREAM: begin
                    if (i_slice_end && last_row) begin
                        o_row_cnt <= '0;
                        state     <= S_WAIT_FIN;
                    end else if (i_slice_end) begin
                        o_row_cnt <= o_row_cnt + 8'd1;
                    end
                end
                S_WAIT_FIN: begin
                    if (fetch_go) begin
                        o_fetch_start <= 1'b1;
                        state         <= S_FETCH;
                    end
                end
                default: begin
                    if (i_fetch_end && !last_col) begin
                        o_col_blk <= o_col_blk + 8'd1;
                        state     <= S_STREAM;
                    end else if (i_fetch_end && !last_layer) begin
                        o_col_blk <= '0;
                        o_layer   <= o_layer + 1'b1;
                        state     <= S_STREAM;
                    end else if (i_fetch_end) begin
                        o_col_blk   <= '0;
                        o_calc_done <= 1'b1;
                        state       <= S_IDLE;
                    end
                end
            endcase
        end
    end

endmodule

// File: verilog/mlp_controller.sv
`timescale 1ns/1ps

module mlp_controller #(
    parameter int N_UNIT      = 4,
    parameter int SLICE_BEATS = 8
) (
    input  logic                                                s_clk,
    input  logic                                                s_rst,
    input  logic                                                i_start,
    input  logic [mlp_pkg::ACT_W-1:0]                           i_act_data,
    input  logic [mlp_pkg::N_ARRAYS-1:0]                        i_slice_ready,
    input  logic [mlp_pkg::N_ARRAYS-1:0][mlp_pkg::PSUM_W-1:0]   i_psum_data,
    input  logic [mlp_pkg::N_ARRAYS-1:0]                        i_finish,
    input  logic signed [mlp_pkg::BIAS_W-1:0]                   i_bias_data,
    output mlp_pkg::layer_idx_t                                 o_act_bank,
    output logic [7:0]                                          o_act_addr,
    output logic [mlp_pkg::N_ARRAYS-1:0]                        o_slice_valid,
    output logic [mlp_pkg::N_ARRAYS-1:0]                        o_slice_done,
    output logic [mlp_pkg::ACT_W-1:0]                           o_slice_data,
    output logic [N_UNIT-1:0]                                   o_psum_grant,
    output logic                                                o_psum_valid,
    output logic [7:0]                                          o_bias_addr,
    output logic                                                o_spike_valid,
    output logic [mlp_pkg::TIME_STEPS-1:0]                      o_spikes,
    output logic                                                o_calc_done
);
    import mlp_pkg::*;

    layer_idx_t                       layer;
    layer_idx_t [1:0]                 layer_pipe;
    logic [7:0]                       col_blk;
    logic [7:0]                       row_cnt;
    logic                             stream_en;
    logic                             fetch_start;
    logic                             slice_end;
    logic                             fetch_end;
    logic                             beat_vld_dly;
    psum_word_u [N_ARRAYS-1:0]        psum_q;
    logic [TIME_STEPS-1:0][SUM_W-1:0] tree_sum;

    always_ff @(posedge s_clk) begin
        for (int a = 0; a < N_ARRAYS; a++) begin
            psum_q[a].flat <= i_psum_data[a];
        end
    end

    // neuron works two cycles behind the fetch beat
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            layer_pipe <= '0;
        end else begin
            layer_pipe <= {layer_pipe[0], layer};
        end
    end

    layer_sequencer #(
        .N_UNIT         (N_UNIT)
    ) u_layer_sequencer (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_start        (i_start),
        .i_slice_end    (slice_end),
        .i_finish       (i_finish),
        .i_fetch_end    (fetch_end),
        .o_layer        (layer),
        .o_col_blk      (col_blk),
        .o_row_cnt      (row_cnt),
        .o_stream_en    (stream_en),
        .o_fetch_start  (fetch_start),
        .o_calc_done    (o_calc_done)
    );

    slice_streamer #(
        .SLICE_BEATS    (SLICE_BEATS)
    ) u_slice_streamer (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_start        (i_start),
        .i_layer        (layer),
        .i_row_cnt      (row_cnt),
        .i_stream_en    (stream_en),
        .i_slice_ready  (i_slice_ready),
        .i_act_data     (i_act_data),
        .o_act_bank     (o_act_bank),
        .o_act_addr     (o_act_addr),
        .o_slice_valid  (o_slice_valid),
        .o_slice_done   (o_slice_done),
        .o_slice_data   (o_slice_data),
        .o_slice_end    (slice_end)
    );

    psum_fetch #(
        .N_UNIT             (N_UNIT)
    ) u_psum_fetch (
        .s_clk              (s_clk),
        .s_rst              (s_rst),
        .i_fetch_start      (fetch_start),
        .i_layer            (layer),
        .i_col_blk          (col_blk),
        .o_psum_valid       (o_psum_valid),
        .o_psum_grant       (o_psum_grant),
        .o_bias_addr        (o_bias_addr),
        .o_fetch_end        (fetch_end),
        .o_beat_valid_dly   (beat_vld_dly)
    );

    psum_add_tree u_psum_add_tree (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_psum         (psum_q),
        .i_bias         (i_bias_data),
        .o_sum          (tree_sum)
    );

    if_neuron u_if_neuron (
        .s_clk          (s_clk),
        .s_rst          (s_rst),
        .i_valid        (beat_vld_dly),
        .i_layer        (layer_pipe[1]),
        .i_sum          (tree_sum),
        .o_spike_valid  (o_spike_valid),
        .o_spikes       (o_spikes)
    );

endmodule

// File: verilog/mlp_pkg.sv
package mlp_pkg;

    localparam int N_ARRAYS   = 3;
    localparam int TIME_STEPS = 4;
    localparam int LANE_W     = 20;
    localparam int PSUM_W     = TIME_STEPS * LANE_W;
    localparam int BIAS_W     = 16;
    localparam int SUM_W      = 22;
    localparam int ACT_W      = 64;
    localparam int NUM_LAYERS = 3;

    typedef logic [1:0] layer_idx_t;

    // projection, hidden expansion, hidden reduction
    localparam int LAYER_ROWS [NUM_LAYERS] = '{3, 3, 6};
    localparam int LAYER_COLS [NUM_LAYERS] = '{2, 4, 2};
    localparam int LAYER_THRD [NUM_LAYERS] = '{128, 256, 128};

    typedef logic signed [LANE_W-1:0] psum_lane_t;

    // lane 0 sits in the low bits of the port word
    typedef union packed {
        logic [PSUM_W-1:0]           flat;
        psum_lane_t [TIME_STEPS-1:0] lane;
    } psum_word_u;

endpackage

// File: verilog/psum_add_tree.sv
`timescale 1ns/1ps

module psum_add_tree (
    input  logic                                                s_clk,
    input  logic                                                s_rst,
    input  mlp_pkg::psum_word_u [mlp_pkg::N_ARRAYS-1:0]         i_psum,
    input  logic signed [mlp_pkg::BIAS_W-1:0]                   i_bias,
    output logic [mlp_pkg::TIME_STEPS-1:0][mlp_pkg::SUM_W-1:0]  o_sum
);
    import mlp_pkg::*;

    logic signed [SUM_W-1:0] sum_c [TIME_STEPS];

    // bias and lanes are sign extended to the tree width
    always_comb begin
        for (int t = 0; t < TIME_STEPS; t++) begin
            sum_c[t] = SUM_W'(i_bias);
            for (int a = 0; a < N_ARRAYS; a++) begin
                sum_c[t] = sum_c[t] + SUM_W'(i_psum[a].lane[t]);
            end
        end
    end

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_sum <= '0;
        end else begin
            for (int t = 0; t < TIME_STEPS; t++) begin
                o_sum[t] <= sum_c[t];
            end
        end
    end

endmodule

// File: verilog/psum_fetch.sv
`timescale 1ns/1ps

module psum_fetch #(
    parameter int N_UNIT = 4
) (
    input  logic                s_clk,
    input  logic                s_rst,
    input  logic                i_fetch_start,
    input  mlp_pkg::layer_idx_t i_layer,
    input  logic [7:0]          i_col_blk,
    output logic                o_psum_valid,
    output logic [N_UNIT-1:0]   o_psum_grant,
    output logic [7:0]          o_bias_addr,
    output logic                o_fetch_end,
    output logic                o_beat_valid_dly
);
    import mlp_pkg::*;

    localparam int BEATS = N_UNIT * N_UNIT;
    localparam int CNT_W = $clog2(BEATS);

    logic [CNT_W-1:0] beat_cnt;
    logic [1:0]       vld_pipe;
    logic [7:0]       layer_base;
    logic             row_last;

    assign row_last         = ((beat_cnt % N_UNIT) == N_UNIT - 1);
    assign o_fetch_end      = o_psum_valid && (beat_cnt == CNT_W'(BEATS - 1));
    assign o_beat_valid_dly = vld_pipe[1];

    // bias words of earlier layers come first
    always_comb begin
        layer_base = '0;
        for (int k = 0; k < NUM_LAYERS; k++) begin
            if (k < i_layer) begin
                layer_base = layer_base + 8'(LAYER_COLS[k] * N_UNIT);
            end
        end
    end

    // one bias per unit row, bias memory answers a cycle later
    assign o_bias_addr = layer_base + 8'(i_col_blk * N_UNIT) + 8'(beat_cnt / N_UNIT);

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            o_psum_valid <= 1'b0;
            o_psum_grant <= '0;
            beat_cnt     <= '0;
            vld_pipe     <= '0;
        end else begin
            vld_pipe <= {vld_pipe[0], o_psum_valid};
            if (i_fetch_start) begin
                o_psum_valid <= 1'b1;
                o_psum_grant <= N_UNIT'(1);
                beat_cnt     <= '0;
            end else if (o_psum_valid) begin
                beat_cnt <= beat_cnt + 1'b1;
                if (o_fetch_end) begin
                    o_psum_valid <= 1'b0;
                    o_psum_grant <= '0;
                end else if (row_last) begin
                    o_psum_grant <= {o_psum_grant[N_UNIT-2:0], o_psum_grant[N_UNIT-1]};
                end
            end
        end
    end

endmodule

// File: verilog/slice_streamer.sv
`timescale 1ns/1ps

module slice_streamer #(
    parameter int SLICE_BEATS = 8
) (
    input  logic                         s_clk,
    input  logic                         s_rst,
    input  logic                         i_start,
    input  mlp_pkg::layer_idx_t          i_layer,
    input  logic [7:0]                   i_row_cnt,
    input  logic                         i_stream_en,
    input  logic [mlp_pkg::N_ARRAYS-1:0] i_slice_ready,
    input  logic [mlp_pkg::ACT_W-1:0]    i_act_data,
    output mlp_pkg::layer_idx_t          o_act_bank,
    output logic [7:0]                   o_act_addr,
    output logic [mlp_pkg::N_ARRAYS-1:0] o_slice_valid,
    output logic [mlp_pkg::N_ARRAYS-1:0] o_slice_done,
    output logic [mlp_pkg::ACT_W-1:0]    o_slice_data,
    output logic                         o_slice_end
);
    import mlp_pkg::*;

    localparam int GNT_W  = $clog2(N_ARRAYS);
    localparam int BEAT_W = (SLICE_BEATS > 1) ? $clog2(SLICE_BEATS) : 1;

    logic [GNT_W-1:0]  grant;
    logic              busy;
    logic              slice_go;
    logic              rd_valid;
    logic              rd_done;
    logic [BEAT_W-1:0] beat_cnt;
    logic [1:0]        vld_pipe;
    logic [1:0]        done_pipe;

    // ready is only looked at when a slice is launched
    assign slice_go    = i_stream_en && !busy && i_slice_ready[grant];
    assign rd_done     = rd_valid && (beat_cnt == BEAT_W'(SLICE_BEATS - 1));
    assign o_slice_end = done_pipe[1];

    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            grant <= '0;
            busy  <= 1'b0;
        end else begin
            if (i_start) begin
                grant <= '0;
            end else if (o_slice_end) begin
                grant <= (grant == GNT_W'(N_ARRAYS - 1)) ? '0 : grant + 1'b1;
            end
            if (slice_go) begin
                busy <= 1'b1;
            end else if (o_slice_end) begin
                busy <= 1'b0;
            end
        end
    end

    // read side, one address per cycle
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            rd_valid   <= 1'b0;
            beat_cnt   <= '0;
            o_act_addr <= '0;
            o_act_bank <= '0;
        end else if (slice_go) begin
            rd_valid   <= 1'b1;
            beat_cnt   <= '0;
            o_act_addr <= 8'(i_row_cnt * SLICE_BEATS);
            o_act_bank <= i_layer;
        end else if (rd_valid) begin
            beat_cnt   <= beat_cnt + 1'b1;
            o_act_addr <= o_act_addr + 8'd1;
            if (rd_done) begin
                rd_valid <= 1'b0;
            end
        end
    end

    // memory latency plus the output register
    always_ff @(posedge s_clk or posedge s_rst) begin
        if (s_rst) begin
            vld_pipe  <= '0;
            done_pipe <= '0;
        end else begin
            vld_pipe  <= {vld_pipe[0], rd_valid};
            done_pipe <= {done_pipe[0], rd_done};
        end
    end

    always_ff @(posedge s_clk) begin
        o_slice_data <= i_act_data;
    end

    always_comb begin
        for (int c = 0; c < N_ARRAYS; c++) begin
            o_slice_valid[c] = vld_pipe[1] && (grant == GNT_W'(c));
            o_slice_done[c]  = done_pipe[1] && (grant == GNT_W'(c));
        end
    end

endmodule
